/* rtl/usb_pid_pkg.sv */
package usb_pid_pkg;

  ////////////////////
  // Packet IDs
  ////////////////////

  // Four-bit PID as seen on the bus after the check nibble is stripped
  // Low two bits give the packet type, high two bits the subtype
  typedef enum logic [3:0] {
    // Token packets
    UsbPidOut   = 4'b0001,
    UsbPidIn    = 4'b1001,
    UsbPidSetup = 4'b1101,
    // Data packets with the toggle in bit 3
    UsbPidData0 = 4'b0011,
    UsbPidData1 = 4'b1011,
    // Handshake packets sent back to the host
    UsbPidAck   = 4'b0010,
    UsbPidNak   = 4'b1010,
    UsbPidStall = 4'b1110
  } usb_pid_e;

  ////////////////////
  // Packet types
  ////////////////////

  // Decoded from PID bits 1 and 0
  typedef enum logic [1:0] {
    UsbPidTypeSpecial   = 2'b00,
    UsbPidTypeToken     = 2'b01,
    UsbPidTypeHandshake = 2'b10,
    UsbPidTypeData      = 2'b11
  } usb_pid_type_e;

endpackage

/* rtl/usb_out_pe_pkg.sv */
package usb_out_pe_pkg;

  ////////////////////
  // Endpoint number
  ////////////////////

  // Full four-bit field as carried in a token
  typedef logic [3:0] ep_num_t;

  ////////////////////
  // Transaction state
  ////////////////////

  // OUT or SETUP transaction sequence
  typedef enum logic [1:0] {
    StIdle          = 2'b00,
    StRcvdOut       = 2'b01,
    StRcvdDataStart = 2'b10,
    StRcvdDataEnd   = 2'b11
  } out_xact_state_e;

  ////////////////////
  // Stage structs
  ////////////////////

  // Decode stage to transaction control
  // One registered cycle per received packet strobe
  typedef struct packed {
    logic    out_tok;
    logic    setup_tok;
    logic    data_pkt;
    logic    data_pid1;
    logic    bad_pkt;
    logic    other_pkt;
    logic    pkt_start;
    ep_num_t ep;
    logic    ep_in_hw;
  } rx_event_t;

  // Transaction control to data delivery
  typedef struct packed {
    logic    in_data;
    logic    rewind;
    logic    restart;
    ep_num_t ep;
  } xact_ctl_t;

endpackage

/* rtl/usb_rx_decode.sv */
`timescale 1ns/1ps

module usb_rx_decode #(
  parameter int unsigned NumOutEps = 2
) (
  input  logic                      clk_48mhz_i,
  input  logic                      rst_ni,
  input  logic [6:0]                dev_addr_i,

  // Receive strobes
  input  logic                      rx_pkt_start_i,
  input  logic                      rx_pkt_end_i,
  input  logic                      rx_pkt_valid_i,

  // Fields of the most recent packet
  input  logic [3:0]                rx_pid_i,
  input  logic [6:0]                rx_addr_i,
  input  logic [3:0]                rx_endp_i,

  output usb_out_pe_pkg::rx_event_t rx_event_o
);

  import usb_pid_pkg::*;
  import usb_out_pe_pkg::*;

  usb_pid_e      rx_pid;
  usb_pid_type_e rx_pid_type;
  logic          good_end;
  logic          tok_for_dev;
  logic          is_data;
  logic          ep_in_hw;
  ep_num_t       ep_sel;
  rx_event_t     event_d;

  // Typed views of the PID nibble
  assign rx_pid      = usb_pid_e'(rx_pid_i);
  assign rx_pid_type = usb_pid_type_e'(rx_pid_i[1:0]);

  ////////////////////
  // Classification
  ////////////////////

  // Packet ended with good CRC and framing
  assign good_end = rx_pkt_end_i && rx_pkt_valid_i;

  // Token addressed to this device
  assign tok_for_dev = good_end && (rx_pid_type == UsbPidTypeToken) &&
                       (rx_addr_i == dev_addr_i);

  assign is_data = (rx_pid == UsbPidData0) || (rx_pid == UsbPidData1);

  // Endpoint numbers beyond the implemented set collapse to 0
  assign ep_in_hw = 32'(rx_endp_i) < NumOutEps;
  assign ep_sel   = ep_in_hw ? rx_endp_i : '0;

  always_comb begin
    event_d           = '0;
    event_d.out_tok   = tok_for_dev && (rx_pid == UsbPidOut);
    event_d.setup_tok = tok_for_dev && (rx_pid == UsbPidSetup);
    event_d.data_pkt  = good_end && is_data;
    // Toggle bit sits in PID bit 3
    event_d.data_pid1 = rx_pid_i[3];
    // Corrupt packet of any kind
    event_d.bad_pkt   = rx_pkt_end_i && !rx_pkt_valid_i;
    // Valid but not a data packet
    event_d.other_pkt = good_end && !is_data;
    event_d.pkt_start = rx_pkt_start_i;
    event_d.ep        = ep_sel;
    event_d.ep_in_hw  = ep_in_hw;
  end

  ////////////////////
  // Event register
  ////////////////////

  // One cycle after the rx strobe
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rx_event_o <= '0;
    end else begin
      rx_event_o <= event_d;
    end
  end

endmodule

/* rtl/usb_out_xact_fsm.sv */
`timescale 1ns/1ps

module usb_out_xact_fsm #(
  parameter int unsigned NumOutEps     = 2,
  parameter int unsigned AckTimeoutCnt = 68
) (
  input  logic                      clk_48mhz_i,
  input  logic                      rst_ni,
  input  logic                      link_reset_i,
  input  usb_out_pe_pkg::rx_event_t rx_event_i,
  input  logic                      refuse_i,
  input  logic [NumOutEps-1:0]      out_ep_enabled_i,
  input  logic [NumOutEps-1:0]      out_ep_control_i,
  input  logic [NumOutEps-1:0]      out_ep_stall_i,
  output usb_out_pe_pkg::xact_ctl_t ctl_o,
  output usb_out_pe_pkg::ep_num_t   out_ep_current_o,
  output logic                      out_ep_newpkt_o,
  output logic [NumOutEps-1:0]      out_ep_setup_o,
  output logic                      out_ep_acked_o,
  output logic                      out_ep_rollback_o,
  output logic                      tx_pkt_start_o,
  output logic [3:0]                tx_pid_o,
  output logic [NumOutEps-1:0]      out_data_toggle_o
);

  import usb_pid_pkg::*;
  import usb_out_pe_pkg::*;

  localparam int unsigned OutEpW = (NumOutEps > 1) ? $clog2(NumOutEps) : 1;
  localparam int unsigned ToW    = $clog2(AckTimeoutCnt + 1);

  out_xact_state_e       state_q, state_d;
  logic [ToW-1:0]        timeout_q, timeout_d;
  logic [NumOutEps-1:0]  toggle_q;
  logic [OutEpW-1:0]     ev_idx, cur_idx;
  logic                  ep_active, ep_is_control, accept_setup, bad_toggle;
  logic                  xact_start, new_pkt_end, setup_xact_q;
  logic                  tx_start_d, acked_d, rollback_d;
  logic [3:0]            tx_pid_d;

  // Index of the token's endpoint and of the current transaction
  assign ev_idx  = rx_event_i.ep[OutEpW-1:0];
  assign cur_idx = out_ep_current_o[OutEpW-1:0];

  assign ep_active     = rx_event_i.ep_in_hw && out_ep_enabled_i[ev_idx];
  assign ep_is_control = out_ep_control_i[ev_idx];
  // SETUP only counts on an active control endpoint
  assign accept_setup  = rx_event_i.setup_tok && ep_active && ep_is_control;
  // Compare against the current endpoint toggle
  assign bad_toggle    = rx_event_i.data_pkt && (rx_event_i.data_pid1 != toggle_q[cur_idx]);

  ////////////////////
  // Next state
  ////////////////////

  always_comb begin
    state_d     = state_q;
    timeout_d   = ToW'(AckTimeoutCnt);
    xact_start  = 1'b0;
    new_pkt_end = 1'b0;
    tx_start_d  = 1'b0;
    tx_pid_d    = 4'b0000;
    acked_d     = 1'b0;
    rollback_d  = 1'b0;
    unique case (state_q)
      StIdle: begin
        // Tokens to absent or disabled endpoints are ignored
        if (ep_active && (rx_event_i.out_tok || accept_setup)) begin
          state_d    = StRcvdOut;
          xact_start = 1'b1;
        end
      end
      StRcvdOut: begin
        // Data packet must start before the count runs out
        timeout_d = timeout_q - 1'b1;
        if (rx_event_i.pkt_start) begin
          state_d = StRcvdDataStart;
        end else if (timeout_q == '0) begin
          state_d = StIdle;
        end
      end
      StRcvdDataStart: begin
        if (bad_toggle && !out_ep_stall_i[cur_idx]) begin
          // Host likely lost our last ACK so repeat it and drop the data
          state_d    = StIdle;
          tx_start_d = 1'b1;
          tx_pid_d   = UsbPidAck;
          rollback_d = 1'b1;
        end else if (rx_event_i.bad_pkt || rx_event_i.other_pkt) begin
          // No handshake at all for these
          state_d    = StIdle;
          rollback_d = 1'b1;
        end else if (rx_event_i.data_pkt) begin
          state_d = StRcvdDataEnd;
        end
      end
      StRcvdDataEnd: begin
        state_d    = StIdle;
        tx_start_d = 1'b1;
        if (setup_xact_q) begin
          // A refused SETUP gets no handshake
          if (refuse_i) begin
            tx_start_d = 1'b0;
            rollback_d = 1'b1;
          end else begin
            tx_pid_d    = UsbPidAck;
            new_pkt_end = 1'b1;
            acked_d     = 1'b1;
          end
        end else if (out_ep_stall_i[cur_idx]) begin
          tx_pid_d = UsbPidStall;
        end else if (refuse_i) begin
          // Endpoint filled up during the packet
          tx_pid_d   = UsbPidNak;
          rollback_d = 1'b1;
        end else begin
          tx_pid_d    = UsbPidAck;
          new_pkt_end = 1'b1;
          acked_d     = 1'b1;
        end
      end
      default: state_d = StIdle;
    endcase
  end

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q           <= StIdle;
      timeout_q         <= ToW'(AckTimeoutCnt);
      tx_pkt_start_o    <= 1'b0;
      tx_pid_o          <= 4'b0000;
      out_ep_acked_o    <= 1'b0;
      out_ep_rollback_o <= 1'b0;
    end else begin
      state_q           <= link_reset_i ? StIdle : state_d;
      timeout_q         <= timeout_d;
      tx_pkt_start_o    <= tx_start_d;
      tx_pid_o          <= tx_pid_d;
      out_ep_acked_o    <= acked_d;
      out_ep_rollback_o <= rollback_d;
    end
  end

  // Endpoint capture at transaction start
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_ep_newpkt_o  <= 1'b0;
      out_ep_current_o <= '0;
      setup_xact_q     <= 1'b0;
    end else begin
      out_ep_newpkt_o <= xact_start;
      if (xact_start) begin
        out_ep_current_o <= rx_event_i.ep;
        setup_xact_q     <= rx_event_i.setup_tok;
      end
    end
  end

  // SETUP flag set by SETUP, cleared by OUT
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_ep_setup_o <= '0;
    end else if (accept_setup) begin
      out_ep_setup_o[ev_idx] <= 1'b1;
    end else if (rx_event_i.out_tok && ep_active) begin
      out_ep_setup_o[ev_idx] <= 1'b0;
    end
  end

  // Data toggles
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      toggle_q <= '0;
    end else if (link_reset_i) begin
      toggle_q <= '0;
    end else if (accept_setup) begin
      toggle_q[ev_idx] <= 1'b0;
    end else if (new_pkt_end) begin
      toggle_q[cur_idx] <= ~toggle_q[cur_idx];
    end
  end

  assign out_data_toggle_o = toggle_q;

  // Controls for the data stage
  always_comb begin
    ctl_o         = '0;
    ctl_o.in_data = (state_q == StRcvdDataStart);
    ctl_o.rewind  = (state_q == StIdle) || (state_q == StRcvdOut);
    ctl_o.restart = (state_q == StRcvdOut);
    ctl_o.ep      = out_ep_current_o;
  end

endmodule

/* rtl/usb_out_data_path.sv */
`timescale 1ns/1ps

module usb_out_data_path #(
  parameter int unsigned NumOutEps         = 2,
  parameter int unsigned MaxOutPktSizeByte = 32,
  localparam int unsigned PktW             = $clog2(MaxOutPktSizeByte)
) (
  input  logic                      clk_48mhz_i,
  input  logic                      rst_ni,
  input  logic                      rx_data_put_i,
  input  logic [7:0]                rx_data_i,
  input  usb_out_pe_pkg::xact_ctl_t ctl_i,
  input  logic [NumOutEps-1:0]      out_ep_full_i,
  output logic [7:0]                out_ep_data_o,
  output logic                      out_ep_data_put_o,
  output logic [PktW-1:0]           out_ep_put_addr_o,
  output logic                      refuse_o
);

  localparam int unsigned OutEpW = (NumOutEps > 1) ? $clog2(NumOutEps) : 1;

  logic [OutEpW-1:0] ep_idx;
  logic              nak_q;
  logic              ep_full;
  logic              advance;

  assign ep_idx  = ctl_i.ep[OutEpW-1:0];
  assign ep_full = out_ep_full_i[ep_idx];

  ////////////////////
  // Byte latch
  ////////////////////

  // Byte and strobe leave together one cycle after the rx put
  always_ff @(posedge clk_48mhz_i) begin
    if (rx_data_put_i) begin
      out_ep_data_o <= rx_data_i;
    end
  end

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_ep_data_put_o <= 1'b0;
    end else begin
      out_ep_data_put_o <= ctl_i.in_data && rx_data_put_i;
    end
  end

  ////////////////////
  // NAK flag
  ////////////////////

  // Any put into a full endpoint spoils the whole packet
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      nak_q <= 1'b0;
    end else if (ctl_i.rewind) begin
      nak_q <= 1'b0;
    end else if (out_ep_data_put_o && ep_full) begin
      nak_q <= 1'b1;
    end
  end

  assign refuse_o = nak_q || ep_full;

  ////////////////////
  // Put offset
  ////////////////////

  // Stops at the top so extra bytes overwrite the last slot
  assign advance = ctl_i.in_data && out_ep_data_put_o && !nak_q && !(&out_ep_put_addr_o);

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_ep_put_addr_o <= '0;
    end else if (ctl_i.restart) begin
      out_ep_put_addr_o <= '0;
    end else if (advance) begin
      out_ep_put_addr_o <= out_ep_put_addr_o + 1'b1;
    end
  end

endmodule

/* rtl/usb_out_pe.sv */
`timescale 1ns/1ps

module usb_out_pe #(
  parameter int unsigned NumOutEps         = 2,
  parameter int unsigned MaxOutPktSizeByte = 32,
  parameter int unsigned AckTimeoutCnt     = 68,
  localparam int unsigned PktW             = $clog2(MaxOutPktSizeByte)
) (
  input  logic                    clk_48mhz_i,
  input  logic                    rst_ni,
  input  logic                    link_reset_i,
  input  logic [6:0]              dev_addr_i,

  // Endpoint interface
  output usb_out_pe_pkg::ep_num_t out_ep_current_o,
  output logic                    out_ep_data_put_o,
  output logic [PktW-1:0]         out_ep_put_addr_o,
  output logic [7:0]              out_ep_data_o,
  output logic                    out_ep_newpkt_o,
  output logic                    out_ep_acked_o,
  output logic                    out_ep_rollback_o,
  output logic [NumOutEps-1:0]    out_ep_setup_o,
  input  logic [NumOutEps-1:0]    out_ep_enabled_i,
  input  logic [NumOutEps-1:0]    out_ep_control_i,
  input  logic [NumOutEps-1:0]    out_ep_full_i,
  input  logic [NumOutEps-1:0]    out_ep_stall_i,
  output logic [NumOutEps-1:0]    out_data_toggle_o,

  // Receive side
  input  logic                    rx_pkt_start_i,
  input  logic                    rx_pkt_end_i,
  input  logic                    rx_pkt_valid_i,
  input  logic [3:0]              rx_pid_i,
  input  logic [6:0]              rx_addr_i,
  input  logic [3:0]              rx_endp_i,
  input  logic                    rx_data_put_i,
  input  logic [7:0]              rx_data_i,

  // Handshake request
  output logic                    tx_pkt_start_o,
  output logic [3:0]              tx_pid_o
);

  import usb_out_pe_pkg::*;

  rx_event_t rx_event;
  xact_ctl_t xact_ctl;
  logic      refuse;

  // Stage 1 packet decode
  usb_rx_decode #(
    .NumOutEps (NumOutEps)
  ) u_rx_decode (
    .clk_48mhz_i    (clk_48mhz_i),
    .rst_ni         (rst_ni),
    .dev_addr_i     (dev_addr_i),
    .rx_pkt_start_i (rx_pkt_start_i),
    .rx_pkt_end_i   (rx_pkt_end_i),
    .rx_pkt_valid_i (rx_pkt_valid_i),
    .rx_pid_i       (rx_pid_i),
    .rx_addr_i      (rx_addr_i),
    .rx_endp_i      (rx_endp_i),
    .rx_event_o     (rx_event)
  );

  // Stage 2 transaction control
  usb_out_xact_fsm #(
    .NumOutEps     (NumOutEps),
    .AckTimeoutCnt (AckTimeoutCnt)
  ) u_xact_fsm (
    .clk_48mhz_i       (clk_48mhz_i),
    .rst_ni            (rst_ni),
    .link_reset_i      (link_reset_i),
    .rx_event_i        (rx_event),
    .refuse_i          (refuse),
    .out_ep_enabled_i  (out_ep_enabled_i),
    .out_ep_control_i  (out_ep_control_i),
    .out_ep_stall_i    (out_ep_stall_i),
    .ctl_o             (xact_ctl),
    .out_ep_current_o  (out_ep_current_o),
    .out_ep_newpkt_o   (out_ep_newpkt_o),
    .out_ep_setup_o    (out_ep_setup_o),
    .out_ep_acked_o    (out_ep_acked_o),
    .out_ep_rollback_o (out_ep_rollback_o),
    .tx_pkt_start_o    (tx_pkt_start_o),
    .tx_pid_o          (tx_pid_o),
    .out_data_toggle_o (out_data_toggle_o)
  );

  // Stage 3 data delivery
  usb_out_data_path #(
    .NumOutEps         (NumOutEps),
    .MaxOutPktSizeByte (MaxOutPktSizeByte)
  ) u_data_path (
    .clk_48mhz_i       (clk_48mhz_i),
    .rst_ni            (rst_ni),
    .rx_data_put_i     (rx_data_put_i),
    .rx_data_i         (rx_data_i),
    .ctl_i             (xact_ctl),
    .out_ep_full_i     (out_ep_full_i),
    .out_ep_data_o     (out_ep_data_o),
    .out_ep_data_put_o (out_ep_data_put_o),
    .out_ep_put_addr_o (out_ep_put_addr_o),
    .refuse_o          (refuse)
  );

endmodule

/* tests/usb_out_pe_checker.sv */
`timescale 1ns/1ps

module usb_out_pe_checker #(
  parameter int unsigned PktW = 5
) (
  input logic            clk_48mhz_i,
  input logic            rst_ni,
  input logic            tx_pkt_start_o,
  input logic            out_ep_data_put_o,
  input logic            out_ep_acked_o,
  input logic            out_ep_rollback_o,
  input logic            out_ep_newpkt_o,
  input logic [PktW-1:0] out_ep_put_addr_o
);

  // Count of failed assertions
  int unsigned err_cnt = 0;

  ////////////////////
  // Strobe exclusion
  ////////////////////

  // Handshake goes out only after the last byte has left
  tx_without_put_a: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    !(tx_pkt_start_o && out_ep_data_put_o))
    else begin
      $error("handshake request overlaps a byte put");
      err_cnt++;
    end

  // One verdict per packet
  acked_xor_rollback_a: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    !(out_ep_acked_o && out_ep_rollback_o))
    else begin
      $error("acked and rollback high together");
      err_cnt++;
    end

  ////////////////////
  // Put offset
  ////////////////////

  // Offset moves up by one or holds
  offset_step_a: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    (out_ep_put_addr_o != '0) |->
      (out_ep_put_addr_o == $past(out_ep_put_addr_o)) ||
      (out_ep_put_addr_o == $past(out_ep_put_addr_o) + 1'b1))
    else begin
      $error("put offset jumped");
      err_cnt++;
    end

  // Return to 0 only right after a new token, never by wrapping
  offset_no_wrap_a: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    ((out_ep_put_addr_o == '0) && ($past(out_ep_put_addr_o) != '0)) |->
      $past(out_ep_newpkt_o))
    else begin
      $error("put offset wrapped");
      err_cnt++;
    end

endmodule

bind usb_out_pe usb_out_pe_checker #(
  .PktW (PktW)
) u_checker (
  .clk_48mhz_i       (clk_48mhz_i),
  .rst_ni            (rst_ni),
  .tx_pkt_start_o    (tx_pkt_start_o),
  .out_ep_data_put_o (out_ep_data_put_o),
  .out_ep_acked_o    (out_ep_acked_o),
  .out_ep_rollback_o (out_ep_rollback_o),
  .out_ep_newpkt_o   (out_ep_newpkt_o),
  .out_ep_put_addr_o (out_ep_put_addr_o)
);

/* tests/tb_usb_out_pe.sv */
`timescale 1ns/1ps

module tb_usb_out_pe;

  import usb_pid_pkg::*;

  localparam int unsigned NumOutEps  = 2;
  localparam int unsigned MaxPkt     = 32;
  localparam int unsigned AckTimeout = 68;
  localparam int unsigned PktW       = $clog2(MaxPkt);
  localparam int unsigned RstCycles  = 8;
  localparam int unsigned NumXact    = 24;
  // Token, gap, 35 bytes at two cycles each, end and handshake, with margin
  localparam int unsigned XactCycles = 200;
  localparam logic [6:0]  DevAddr    = 7'h2a;

  // Expected outcome of one transaction
  typedef struct packed {
    logic     resp;
    usb_pid_e pid;
    logic     acked;
    logic     rollback;
    logic     toggle;
  } expect_t;

  logic                 clk_48mhz_i, rst_ni, link_reset_i;
  logic [6:0]           dev_addr_i;
  logic [3:0]           out_ep_current_o;
  logic                 out_ep_data_put_o;
  logic [PktW-1:0]      out_ep_put_addr_o;
  logic [7:0]           out_ep_data_o;
  logic                 out_ep_newpkt_o, out_ep_acked_o, out_ep_rollback_o;
  logic [NumOutEps-1:0] out_ep_setup_o, out_ep_enabled_i, out_ep_control_i;
  logic [NumOutEps-1:0] out_ep_full_i, out_ep_stall_i, out_data_toggle_o;
  logic                 rx_pkt_start_i, rx_pkt_end_i, rx_pkt_valid_i;
  logic [3:0]           rx_pid_i, rx_endp_i;
  logic [6:0]           rx_addr_i;
  logic                 rx_data_put_i;
  logic [7:0]           rx_data_i;
  logic                 tx_pkt_start_o;
  logic [3:0]           tx_pid_o;

  // Monitor record and model state
  logic [7:0]              got_data[$], sent_q[$];
  logic [PktW-1:0]         got_off[$];
  int                      tx_cnt, acked_cnt, rollback_cnt, newpkt_cnt;
  usb_pid_e                tx_pid;
  usb_out_pe_pkg::ep_num_t got_ep;
  logic [NumOutEps-1:0]    exp_tog;
  logic [31:0]             rng_state;

  usb_out_pe UUT (.*);

  initial begin
    clk_48mhz_i = 1'b0;
    forever #50 clk_48mhz_i = ~clk_48mhz_i;
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic fail_run(string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  function automatic logic [31:0] xorshift32(logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Response rules for one OUT or SETUP data packet
  function automatic expect_t ref_xact(bit setup, bit data1, bit tog, bit stall,
                                       bit full, bit bad);
    expect_t e;
    e = '{resp: 1'b0, pid: UsbPidAck, acked: 1'b0, rollback: 1'b0, toggle: tog};
    if (bad) begin
      e.rollback = 1'b1;
    end else if ((data1 != tog) && !stall) begin
      // Repeated packet, ACK again and drop it
      e.resp     = 1'b1;
      e.rollback = 1'b1;
    end else if (setup && full) begin
      e.rollback = 1'b1;
    end else if (!setup && stall) begin
      e.resp = 1'b1;
      e.pid  = UsbPidStall;
    end else if (!setup && full) begin
      e.resp     = 1'b1;
      e.pid      = UsbPidNak;
      e.rollback = 1'b1;
    end else begin
      e.resp   = 1'b1;
      e.acked  = 1'b1;
      e.toggle = ~tog;
    end
    return e;
  endfunction

  // Offset advances after each put unless NAK pending or at the top
  function automatic logic [PktW-1:0] ref_offset(int idx, bit full);
    int o;
    bit nak;
    o   = 0;
    nak = 1'b0;
    for (int i = 0; i < idx; i++) begin
      if (!nak && (o < MaxPkt - 1)) o++;
      if (full) nak = 1'b1;
    end
    return PktW'(o);
  endfunction

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_pid(usb_pid_e exp, usb_pid_e got);
    if (exp != got) begin
      $display("[ERROR] %0t tx_pid_o exp %s got %s", $time, exp.name(), got.name());
      fail_run("handshake PID mismatch");
    end
  endtask

  task automatic check_byte(logic [7:0] exp_d, logic [7:0] got_d,
                            logic [PktW-1:0] exp_off, logic [PktW-1:0] got_off);
    if ((exp_d !== got_d) || (exp_off !== got_off)) begin
      $display("[ERROR] %0t out_ep_data_o exp %h got %h, out_ep_put_addr_o exp %0d got %0d",
               $time, exp_d, got_d, exp_off, got_off);
      fail_run("delivered byte mismatch");
    end
  endtask

  task automatic check_toggle(logic [NumOutEps-1:0] exp, logic [NumOutEps-1:0] got);
    if (exp !== got) begin
      $display("[ERROR] %0t out_data_toggle_o exp %b got %b", $time, exp, got);
      fail_run("data toggle mismatch");
    end
  endtask

  task automatic check_ep(usb_out_pe_pkg::ep_num_t exp, usb_out_pe_pkg::ep_num_t got);
    if (exp !== got) begin
      $display("[ERROR] %0t out_ep_current_o exp %0d got %0d", $time, exp, got);
      fail_run("current endpoint mismatch");
    end
  endtask

  task automatic check_bit(string name, logic exp, logic got);
    if (exp !== got) begin
      $display("[ERROR] %0t %s exp %b got %b", $time, name, exp, got);
      fail_run("strobe mismatch");
    end
  endtask

  ////////////////////
  // Monitor
  ////////////////////

  // Registered outputs are stable at the falling edge
  always @(negedge clk_48mhz_i) begin
    if (rst_ni) begin
      if (out_ep_data_put_o) begin
        got_data.push_back(out_ep_data_o);
        got_off.push_back(out_ep_put_addr_o);
      end
      if (tx_pkt_start_o) begin
        tx_cnt++;
        tx_pid = usb_pid_e'(tx_pid_o);
      end
      if (out_ep_acked_o) acked_cnt++;
      if (out_ep_rollback_o) rollback_cnt++;
      if (out_ep_newpkt_o) begin
        newpkt_cnt++;
        got_ep = out_ep_current_o;
      end
      if (UUT.u_checker.err_cnt != 0) fail_run("assertion in the bound checker failed");
    end
  end

  task automatic clear_monitor();
    got_data.delete();
    got_off.delete();
    sent_q.delete();
    tx_cnt       = 0;
    acked_cnt    = 0;
    rollback_cnt = 0;
    newpkt_cnt   = 0;
  endtask

  ////////////////////
  // Packet driver
  ////////////////////

  task automatic send_token(usb_pid_e pid, logic [6:0] addr, logic [3:0] ep);
    @(negedge clk_48mhz_i);
    rx_pkt_start_i = 1'b1;
    @(negedge clk_48mhz_i);
    rx_pkt_start_i = 1'b0;
    rx_pid_i       = pid;
    rx_addr_i      = addr;
    rx_endp_i      = ep;
    rx_pkt_valid_i = 1'b1;
    rx_pkt_end_i   = 1'b1;
    @(negedge clk_48mhz_i);
    rx_pkt_end_i   = 1'b0;
    rx_pkt_valid_i = 1'b0;
  endtask

  // Random payload, valid low gives a corrupt packet
  task automatic send_data(usb_pid_e pid, int nbytes, bit valid);
    @(negedge clk_48mhz_i);
    rx_pkt_start_i = 1'b1;
    @(negedge clk_48mhz_i);
    rx_pkt_start_i = 1'b0;
    @(negedge clk_48mhz_i);
    for (int i = 0; i < nbytes; i++) begin
      rng_state     = xorshift32(rng_state);
      rx_data_i     = rng_state[7:0];
      rx_data_put_i = 1'b1;
      sent_q.push_back(rng_state[7:0]);
      @(negedge clk_48mhz_i);
      rx_data_put_i = 1'b0;
      @(negedge clk_48mhz_i);
    end
    rx_pid_i       = pid;
    rx_pkt_valid_i = valid;
    rx_pkt_end_i   = 1'b1;
    @(negedge clk_48mhz_i);
    rx_pkt_end_i   = 1'b0;
    rx_pkt_valid_i = 1'b0;
  endtask

  // Handshake or rollback, whichever comes
  task automatic wait_outcome();
    bit seen;
    seen = 1'b0;
    for (int i = 0; i < 16 && !seen; i++) begin
      @(posedge clk_48mhz_i);
      seen = (tx_cnt != 0) || (rollback_cnt != 0);
    end
    if (!seen) fail_run("no handshake or rollback after the data packet");
    repeat (3) @(negedge clk_48mhz_i);
  endtask

  task automatic run_xact(int ep, bit setup, bit data1, int nbytes, bit valid);
    expect_t exp;
    clear_monitor();
    send_token(setup ? UsbPidSetup : UsbPidOut, DevAddr, 4'(ep));
    send_data(data1 ? UsbPidData1 : UsbPidData0, nbytes, valid);
    wait_outcome();
    exp = ref_xact(setup, data1, setup ? 1'b0 : exp_tog[ep], out_ep_stall_i[ep],
                   out_ep_full_i[ep], !valid);
    check_bit("out_ep_newpkt_o", 1'b1, newpkt_cnt == 1);
    check_ep(usb_out_pe_pkg::ep_num_t'(ep), got_ep);
    check_bit("tx_pkt_start_o", exp.resp, tx_cnt == 1);
    if (exp.resp) check_pid(exp.pid, tx_pid);
    check_bit("out_ep_acked_o", exp.acked, acked_cnt == 1);
    check_bit("out_ep_rollback_o", exp.rollback, rollback_cnt == 1);
    check_bit("out_ep_setup_o", setup, out_ep_setup_o[ep]);
    if (got_data.size() != nbytes) fail_run("wrong number of bytes delivered");
    for (int i = 0; i < nbytes; i++) begin
      check_byte(sent_q[i], got_data[i], ref_offset(i, out_ep_full_i[ep]), got_off[i]);
    end
    exp_tog[ep] = exp.toggle;
    check_toggle(exp_tog, out_data_toggle_o);
  endtask

  // Token that must be ignored
  task automatic run_ignored(usb_pid_e pid, logic [6:0] addr, logic [3:0] ep);
    clear_monitor();
    send_token(pid, addr, ep);
    repeat (6) @(negedge clk_48mhz_i);
    check_bit("out_ep_newpkt_o", 1'b0, newpkt_cnt != 0);
    check_bit("tx_pkt_start_o", 1'b0, tx_cnt != 0);
    check_bit("out_ep_setup_o", 1'b0, |out_ep_setup_o);
    check_toggle(exp_tog, out_data_toggle_o);
  endtask

  initial begin
    #((RstCycles + NumXact * XactCycles) * 100);
    fail_run("watchdog expired before the tests finished");
  end

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    rst_ni = 1'b0;
    link_reset_i = 1'b0;
    dev_addr_i = DevAddr;
    out_ep_enabled_i = 2'b11;
    out_ep_control_i = 2'b01;
    out_ep_full_i = 2'b00;
    out_ep_stall_i = 2'b00;
    rx_pkt_start_i = 1'b0;
    rx_pkt_end_i = 1'b0;
    rx_pkt_valid_i = 1'b0;
    rx_pid_i = 4'h0;
    rx_addr_i = 7'h00;
    rx_endp_i = 4'h0;
    rx_data_put_i = 1'b0;
    rx_data_i = 8'h00;
    exp_tog = '0;
    rng_state = 32'd47519;
    clear_monitor();
    repeat (RstCycles) @(negedge clk_48mhz_i);
    rst_ni = 1'b1;

    // Plain OUT on both endpoints, then a repeated DATA0
    run_xact(0, 1'b0, 1'b0, 8, 1'b1);
    run_xact(1, 1'b0, 1'b0, 4, 1'b1);
    run_xact(0, 1'b0, 1'b0, 3, 1'b1);

    // Stalled endpoint answers STALL
    @(negedge clk_48mhz_i);
    out_ep_stall_i = 2'b10;
    run_xact(1, 1'b0, 1'b0, 3, 1'b1);
    out_ep_stall_i = 2'b00;

    // Full endpoint answers NAK
    @(negedge clk_48mhz_i);
    out_ep_full_i = 2'b01;
    run_xact(0, 1'b0, 1'b1, 5, 1'b1);
    out_ep_full_i = 2'b00;

    // Oversized packet saturates the offset
    run_xact(0, 1'b0, 1'b1, MaxPkt + 3, 1'b1);

    // Toggle left at 1 so the SETUP clear shows
    run_xact(0, 1'b0, 1'b0, 2, 1'b1);

    // SETUP on the control endpoint then OUT clears the flag
    run_xact(0, 1'b1, 1'b0, 8, 1'b1);
    run_xact(0, 1'b0, 1'b1, 2, 1'b1);

    // Refused tokens
    run_ignored(UsbPidSetup, DevAddr, 4'd1);
    run_ignored(UsbPidSetup, DevAddr + 7'd1, 4'd0);
    run_ignored(UsbPidSetup, DevAddr, 4'd5);

    // Missing data packet times out
    clear_monitor();
    send_token(UsbPidOut, DevAddr, 4'd1);
    repeat (AckTimeout + 8) @(posedge clk_48mhz_i);
    check_bit("out_ep_newpkt_o", 1'b1, newpkt_cnt == 1);
    check_ep(usb_out_pe_pkg::ep_num_t'(1), got_ep);
    check_bit("tx_pkt_start_o", 1'b0, tx_cnt != 0);
    run_xact(1, 1'b0, 1'b1, 3, 1'b1);

    // Corrupt data packet
    run_xact(1, 1'b0, 1'b0, 3, 1'b0);

    // Link reset clears toggles
    run_xact(0, 1'b0, 1'b0, 4, 1'b1);
    run_xact(1, 1'b0, 1'b0, 2, 1'b1);
    @(negedge clk_48mhz_i);
    link_reset_i = 1'b1;
    @(negedge clk_48mhz_i);
    link_reset_i = 1'b0;
    @(negedge clk_48mhz_i);
    exp_tog = '0;
    check_toggle(exp_tog, out_data_toggle_o);
    run_xact(0, 1'b0, 1'b0, 2, 1'b1);
    run_xact(1, 1'b0, 1'b0, 2, 1'b1);

    // Reset clears toggles
    @(negedge clk_48mhz_i);
    rst_ni = 1'b0;
    repeat (RstCycles) @(negedge clk_48mhz_i);
    rst_ni = 1'b1;
    @(negedge clk_48mhz_i);
    exp_tog = '0;
    check_toggle(exp_tog, out_data_toggle_o);
    run_xact(0, 1'b0, 1'b0, 2, 1'b1);

    if (UUT.u_checker.err_cnt != 0) begin
      fail_run("assertion in the bound checker failed");
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

/* vlog.f */
rtl/usb_pid_pkg.sv
rtl/usb_out_pe_pkg.sv
rtl/usb_rx_decode.sv
rtl/usb_out_xact_fsm.sv
rtl/usb_out_data_path.sv
rtl/usb_out_pe.sv
tests/usb_out_pe_checker.sv
tests/tb_usb_out_pe.sv

/* Bender.yml */
package:
  name: usb_out_pe

sources:
  - rtl/usb_pid_pkg.sv
  - rtl/usb_out_pe_pkg.sv
  - rtl/usb_rx_decode.sv
  - rtl/usb_out_xact_fsm.sv
  - rtl/usb_out_data_path.sv
  - rtl/usb_out_pe.sv
  - target: test
    files:
      - tests/usb_out_pe_checker.sv
      - tests/tb_usb_out_pe.sv
